// ==== dv/io_golden.mem ====
// test op addr data mask chk exp_read exp_irq exp_anode exp_cathode
// op 0 write, 1 read, 2 set switches, 3 wait data cycles, F stop
// chk bit 0 read_data_o, 1 interrupt_o, 2 anode and cathode, 3 last check of the test
// Test 1: display register readback and byte masks
1 0 FFFF0204 12345678 F 0 00000000 0 FF FF
1 1 FFFF0204 00000000 0 1 12345678 0 FF FF
1 0 FFFF0204 AABBCCDD 5 0 00000000 0 FF FF
1 1 FFFF0204 00000000 0 1 12BB56DD 0 FF FF
1 0 FFFF0200 0000A5A4 2 0 00000000 0 FF FF
1 1 FFFF0200 00000000 0 D 0000A500 0 FF FF
// Test 2: unmapped reads return zero
2 1 00001000 00000000 0 1 00000000 0 FF FF
2 1 FFFF0208 00000000 0 1 00000000 0 FF FF
2 1 FFFF0500 00000000 0 9 00000000 0 FF FF
// Test 3: switch sync latency, pending set, active masked
3 0 FFFF0000 00000003 F 0 00000000 0 FF FF
3 2 00000000 0000A5C3 0 0 00000000 0 FF FF
3 1 FFFF0300 00000000 0 1 00000000 0 FF FF
3 1 FFFF0300 00000000 0 1 0000A5C3 0 FF FF
3 1 FFFF0000 00000000 0 1 00000001 0 FF FF
3 1 FFFF0008 00000000 0 B 00000000 0 FF FF
// Test 4: enable raises interrupt, write 1 clears it, refresh bit stays
4 0 FFFF0004 00000001 1 2 00000000 1 FF FF
4 1 FFFF0008 00000000 0 3 00000001 1 FF FF
4 0 FFFF0000 00000001 1 2 00000000 0 FF FF
4 1 FFFF0000 00000000 0 B 00000002 0 FF FF
// Test 5: digit scan of 89ABCDEF starting at digit 4, refresh interrupt, disable
5 0 FFFF0000 00000002 1 0 00000000 0 FF FF
5 1 FFFF0000 00000000 0 5 00000000 0 FF FF
5 0 FFFF0204 89ABCDEF F 0 00000000 0 FF FF
5 0 FFFF0200 00000001 1 0 00000000 0 FF FF
5 3 00000000 00000001 0 4 00000000 0 EF 83
5 3 00000000 00000004 0 4 00000000 0 DF 88
5 3 00000000 00000004 0 4 00000000 0 BF 90
5 3 00000000 00000004 0 4 00000000 0 7F 80
5 3 00000000 00000004 0 4 00000000 0 FE 8E
5 3 00000000 00000004 0 4 00000000 0 FD 86
5 3 00000000 00000004 0 4 00000000 0 FB A1
5 3 00000000 00000004 0 4 00000000 0 F7 C6
5 3 00000000 00000004 0 4 00000000 0 EF 83
5 1 FFFF0000 00000000 0 3 00000002 0 FF FF
5 0 FFFF0200 00000000 1 0 00000000 0 FF FF
5 3 00000000 00000001 0 4 00000000 0 FF FF
5 1 FFFF0200 00000000 0 D 0000A500 0 FF FF
// End of sequence
0 F 00000000 00000000 0 0 00000000 0 00 00

// ==== io_chipset.f ====
rtl/io_pkg.sv
rtl/io_decode.sv
rtl/irq_controller.sv
rtl/switch_port.sv
rtl/scan_timer.sv
rtl/seg_display.sv
rtl/io_chipset.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_top -f io_chipset.f -o tb_top
./obj_dir/tb_top | tee sim.log
if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1

// ==== dv/tb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_top;

    localparam int FIELDS  = 10;
    localparam int ENTRIES = 64;

    // Golden file operations
    localparam logic [3:0] OP_WRITE  = 4'h0;
    localparam logic [3:0] OP_READ   = 4'h1;
    localparam logic [3:0] OP_SWITCH = 4'h2;
    localparam logic [3:0] OP_WAIT   = 4'h3;
    localparam logic [3:0] OP_STOP   = 4'hF;

    wire logic        cpu_clk;
    wire logic        rst_n;

    logic [31:0]      addr;
    logic             read_enable;
    logic [31:0]      write_data;
    logic [3:0]       write_mask;
    logic [15:0]      switches;
    wire logic [31:0] read_data;
    wire logic        cpu_irq;
    wire logic [7:0]  dsp_anode;
    wire logic [7:0]  dsp_cathode;

    // Expectation handed to the checker
    logic [7:0]       exp_test;
    logic [3:0]       exp_chk;
    logic [31:0]      exp_due;
    logic [31:0]      exp_read;
    logic             exp_irq;
    logic [7:0]       exp_anode;
    logic [7:0]       exp_cathode;
    logic             done;
    wire logic [31:0] error_count;
    wire logic [31:0] check_count;

    logic [31:0]      golden [0:ENTRIES*FIELDS-1];
    logic [31:0]      cycle = '0;
    logic [31:0]      limit;
    int               entry_count;
    int               bad_entries;

    tb_clock clock0 (
        .clk_o   (cpu_clk),
        .rst_n_o (rst_n)
    );

    io_chipset #(
        .CLK_DIVISOR (4)
    ) dut0 (
        .cpu_clk_i     (cpu_clk),
        .rst_n_i       (rst_n),
        .addr_i        (addr),
        .read_enable_i (read_enable),
        .write_data_i  (write_data),
        .write_mask_i  (write_mask),
        .read_data_o   (read_data),
        .interrupt_o   (cpu_irq),
        .switch_i      (switches),
        .dsp_anode_o   (dsp_anode),
        .dsp_cathode_o (dsp_cathode)
    );

    tb_checker checker0 (
        .cpu_clk_i     (cpu_clk),
        .cycle_i       (cycle),
        .due_i         (exp_due),
        .chk_i         (exp_chk),
        .test_i        (exp_test),
        .exp_read_i    (exp_read),
        .exp_irq_i     (exp_irq),
        .exp_anode_i   (exp_anode),
        .exp_cathode_i (exp_cathode),
        .read_data_i   (read_data),
        .interrupt_i   (cpu_irq),
        .dsp_anode_i   (dsp_anode),
        .dsp_cathode_i (dsp_cathode),
        .done_i        (done),
        .error_count_o (error_count),
        .check_count_o (check_count)
    );

    always @(posedge cpu_clk) begin
        cycle <= cycle + 32'd1;
    end

    always @(posedge cpu_clk) begin
        if (cycle >= limit) begin
            $display("timeout: golden sequence did not finish");
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d,
                             input logic [3:0] m);
        @(posedge cpu_clk);
        addr       <= a;
        write_data <= d;
        write_mask <= m;
        @(posedge cpu_clk);
        addr       <= '0;
        write_data <= '0;
        write_mask <= 4'h0;
    endtask

    task automatic bus_read(input logic [31:0] a);
        @(posedge cpu_clk);
        addr        <= a;
        read_enable <= 1'b1;
        @(posedge cpu_clk);
        addr        <= '0;
        read_enable <= 1'b0;
    endtask

    task automatic drive_switches(input logic [15:0] d);
        @(posedge cpu_clk);
        switches <= d;
        @(posedge cpu_clk);
    endtask

    task automatic idle_cycles(input logic [31:0] n);
        repeat (n) @(posedge cpu_clk);
    endtask

    // Runs right after an edge, so cycle still holds the count before it
    task automatic post_expect(input int base);
        exp_test    <= golden[base][7:0];
        exp_chk     <= golden[base + 5][3:0];
        exp_read    <= golden[base + 6];
        exp_irq     <= golden[base + 7][0];
        exp_anode   <= golden[base + 8][7:0];
        exp_cathode <= golden[base + 9][7:0];
        exp_due     <= cycle + 32'd1;
    endtask

    task automatic run_entry(input int base);
        logic [3:0]  op;
        logic [31:0] data;
        op   = golden[base + 1][3:0];
        data = golden[base + 3];
        case (op)
            OP_WRITE:  bus_write(golden[base + 2], data, golden[base + 4][3:0]);
            OP_READ:   bus_read(golden[base + 2]);
            OP_SWITCH: drive_switches(data[15:0]);
            OP_WAIT:   idle_cycles(data);
            default: begin
                $display("golden entry at word %0d has an unknown operation %h", base, op);
                bad_entries = bad_entries + 1;
            end
        endcase
        if (op <= OP_WAIT) begin
            post_expect(base);
        end
    endtask

    initial begin
        addr        = '0;
        read_enable = 1'b0;
        write_data  = '0;
        write_mask  = 4'h0;
        switches    = '0;
        exp_test    = '0;
        exp_chk     = 4'h0;
        exp_due     = '0;
        exp_read    = '0;
        exp_irq     = 1'b0;
        exp_anode   = 8'hFF;
        exp_cathode = 8'hFF;
        done        = 1'b0;
        bad_entries = 0;
        entry_count = 0;
        $readmemh("dv/io_golden.mem", golden);
        // Waits plus 4 cycles per entry plus margin
        limit = 32'd100;
        while (entry_count < ENTRIES && golden[entry_count * FIELDS + 1][3:0] != OP_STOP) begin
            limit = limit + 32'd4;
            if (golden[entry_count * FIELDS + 1][3:0] == OP_WAIT) begin
                limit = limit + golden[entry_count * FIELDS + 3];
            end
            entry_count = entry_count + 1;
        end
        wait (rst_n === 1'b1);
        for (int i = 0; i < entry_count; i++) begin
            run_entry(i * FIELDS);
        end
        // Last check runs at the next falling edge, summary after that
        @(posedge cpu_clk);
        done <= 1'b1;
        @(posedge cpu_clk);
        if (error_count == 32'd0 && check_count != 32'd0 && bad_entries == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
    input  wire logic        cpu_clk_i,

    // Expectation from the golden sequence
    input  wire logic [31:0] cycle_i,
    input  wire logic [31:0] due_i,
    input  wire logic [3:0]  chk_i,
    input  wire logic [7:0]  test_i,
    input  wire logic [31:0] exp_read_i,
    input  wire logic        exp_irq_i,
    input  wire logic [7:0]  exp_anode_i,
    input  wire logic [7:0]  exp_cathode_i,

    // Observed DUT outputs
    input  wire logic [31:0] read_data_i,
    input  wire logic        interrupt_i,
    input  wire logic [7:0]  dsp_anode_i,
    input  wire logic [7:0]  dsp_cathode_i,

    input  wire logic        done_i,
    output logic [31:0]      error_count_o,
    output logic [31:0]      check_count_o
);

    int   checks       = 0;
    int   errors       = 0;
    int   test_checks  = 0;
    int   test_errors  = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    logic summary_done = 1'b0;

    assign error_count_o = errors;
    assign check_count_o = checks;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks      = checks + 1;
        test_checks = test_checks + 1;
        if (actual !== expected) begin
            $display("[ERROR] t=%0d ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
            errors      = errors + 1;
            test_errors = test_errors + 1;
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %0d: PASS (%0d checks)", test_i, test_checks);
            tests_passed = tests_passed + 1;
        end else begin
            $display("test %0d: FAIL (%0d of %0d checks wrong)", test_i, test_errors,
                     test_checks);
            tests_failed = tests_failed + 1;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge cpu_clk_i) begin
        if (chk_i != 4'h0 && cycle_i == due_i) begin
            if (chk_i[0]) begin
                compare_value("read_data_o", exp_read_i, read_data_i);
            end
            if (chk_i[1]) begin
                compare_value("interrupt_o", 32'(exp_irq_i), 32'(interrupt_i));
            end
            if (chk_i[2]) begin
                compare_value("dsp_anode_o", 32'(exp_anode_i), 32'(dsp_anode_i));
                compare_value("dsp_cathode_o", 32'(exp_cathode_i), 32'(dsp_cathode_i));
            end
            if (chk_i[3]) begin
                finish_test();
            end
        end
        if (done_i && !summary_done) begin
            $display("checks %0d, errors %0d, tests passed %0d, tests failed %0d",
                     checks, errors, tests_passed, tests_failed);
            summary_done = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Reset held low for the first 10 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== rtl/io_chipset.sv ====
`timescale 1ns/100ps
`default_nettype none

module io_chipset
    import io_pkg::*;
#(
    parameter int CLK_DIVISOR = 50000
) (
    input  wire logic        cpu_clk_i,
    input  wire logic        rst_n_i,

    // CPU data bus
    input  wire word_t       addr_i,
    input  wire logic        read_enable_i,
    input  wire word_t       write_data_i,
    input  wire logic [3:0]  write_mask_i,
    output word_t            read_data_o,

    output logic             interrupt_o,

    // Board I/O
    input  wire logic [15:0] switch_i,
    output logic [7:0]       dsp_anode_o,
    output logic [7:0]       dsp_cathode_o
);

    localparam int IRQ_COUNT = 2;

    wire logic                 irq_sel;
    wire logic                 dsp_sel;
    wire logic                 sw_sel;
    wire word_t                irq_read_data;
    wire word_t                dsp_read_data;
    wire word_t                sw_read_data;
    wire logic                 sw_change;
    wire logic                 dsp_refresh;
    wire logic [IRQ_COUNT-1:0] irq_sources;

    assign irq_sources[IRQ_SW]          = sw_change;
    assign irq_sources[IRQ_DSP_REFRESH] = dsp_refresh;

    io_decode decode0 (
        .cpu_clk_i   (cpu_clk_i),
        .rst_n_i     (rst_n_i),
        .addr_i      (addr_i),
        .irq_data_i  (irq_read_data),
        .dsp_data_i  (dsp_read_data),
        .sw_data_i   (sw_read_data),
        .irq_sel_o   (irq_sel),
        .dsp_sel_o   (dsp_sel),
        .sw_sel_o    (sw_sel),
        .read_data_o (read_data_o)
    );

    irq_controller #(
        .IRQ_COUNT (IRQ_COUNT)
    ) irq0 (
        .cpu_clk_i     (cpu_clk_i),
        .rst_n_i       (rst_n_i),
        .sel_i         (irq_sel),
        .reg_i         (addr_i[5:2]),
        .read_enable_i (read_enable_i),
        .write_data_i  (write_data_i),
        .write_mask_i  (write_mask_i),
        .read_data_o   (irq_read_data),
        .irq_i         (irq_sources),
        .interrupt_o   (interrupt_o)
    );

    switch_port switches0 (
        .cpu_clk_i     (cpu_clk_i),
        .rst_n_i       (rst_n_i),
        .switch_i      (switch_i),
        .sel_i         (sw_sel),
        .reg_i         (addr_i[5:2]),
        .read_enable_i (read_enable_i),
        .read_data_o   (sw_read_data),
        .change_o      (sw_change)
    );

    seg_display #(
        .CLK_DIVISOR (CLK_DIVISOR)
    ) display0 (
        .cpu_clk_i     (cpu_clk_i),
        .rst_n_i       (rst_n_i),
        .sel_i         (dsp_sel),
        .reg_i         (addr_i[5:2]),
        .read_enable_i (read_enable_i),
        .write_data_i  (write_data_i),
        .write_mask_i  (write_mask_i),
        .read_data_o   (dsp_read_data),
        .refresh_o     (dsp_refresh),
        .dsp_anode_o   (dsp_anode_o),
        .dsp_cathode_o (dsp_cathode_o)
    );

endmodule

`default_nettype wire

// ==== rtl/seg_display.sv ====
`timescale 1ns/100ps
`default_nettype none

module seg_display
    import io_pkg::*;
#(
    parameter int CLK_DIVISOR = 50000
) (
    input  wire logic       cpu_clk_i,
    input  wire logic       rst_n_i,

    // Register port
    input  wire logic       sel_i,
    input  wire logic [3:0] reg_i,
    input  wire logic       read_enable_i,
    input  wire word_t      write_data_i,
    input  wire logic [3:0] write_mask_i,
    output word_t           read_data_o,

    // Pulses once per full scan of the eight digits
    output logic            refresh_o,

    // Active-low display drive
    output logic [7:0]      dsp_anode_o,
    output logic [7:0]      dsp_cathode_o
);

    word_t      control_r;
    word_t      value_r;
    word_t      byte_bits;
    logic       wr_en;
    logic [2:0] digit_w;
    logic       wrap_w;

    scan_timer #(
        .CLK_DIVISOR (CLK_DIVISOR)
    ) timer0 (
        .cpu_clk_i (cpu_clk_i),
        .rst_n_i   (rst_n_i),
        .digit_o   (digit_w),
        .wrap_o    (wrap_w)
    );

    assign refresh_o = wrap_w;

    assign byte_bits = {{8{write_mask_i[3]}}, {8{write_mask_i[2]}},
                        {8{write_mask_i[1]}}, {8{write_mask_i[0]}}};
    assign wr_en     = sel_i && (write_mask_i != 4'b0000);

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            control_r <= '0;
            value_r   <= '0;
        end else if (wr_en) begin
            if (reg_i == REG_DSP_CONTROL) begin
                control_r <= (control_r & ~byte_bits) | (write_data_i & byte_bits);
            end
            if (reg_i == REG_DSP_VALUE) begin
                value_r <= (value_r & ~byte_bits) | (write_data_i & byte_bits);
            end
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (sel_i && read_enable_i) begin
            case (reg_i)
                REG_DSP_CONTROL: read_data_o <= control_r;
                REG_DSP_VALUE:   read_data_o <= value_r;
                default:         read_data_o <= '0;
            endcase
        end
    end

    // Digit n shows value nibble n, one cycle behind the index
    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            dsp_anode_o   <= 8'hFF;
            dsp_cathode_o <= 8'hFF;
        end else if (control_r[0]) begin
            dsp_anode_o   <= ~(8'b1 << digit_w);
            dsp_cathode_o <= hex_segments(value_r[{digit_w, 2'b00} +: 4]);
        end else begin
            dsp_anode_o   <= 8'hFF;
            dsp_cathode_o <= 8'hFF;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/scan_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module scan_timer #(
    parameter int CLK_DIVISOR = 50000
) (
    input  wire logic cpu_clk_i,
    input  wire logic rst_n_i,
    output logic [2:0] digit_o,
    output logic       wrap_o
);

    localparam int CW = (CLK_DIVISOR > 1) ? $clog2(CLK_DIVISOR) : 1;

    logic [CW-1:0] count_r;
    logic          tick;

    assign tick = (count_r == '0);

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            count_r <= '0;
            digit_o <= 3'd0;
            wrap_o  <= 1'b0;
        end else begin
            wrap_o <= 1'b0;
            if (tick) begin
                count_r <= CW'(CLK_DIVISOR - 1);
                digit_o <= digit_o + 3'd1;
                // Last digit done, whole display refreshed
                wrap_o  <= (digit_o == 3'd7);
            end else begin
                count_r <= count_r - 1'b1;
            end
        end
    end

    divisor_range_a: assert property (@(posedge cpu_clk_i) CLK_DIVISOR >= 2);

endmodule

`default_nettype wire

// ==== rtl/switch_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module switch_port
    import io_pkg::*;
(
    input  wire logic        cpu_clk_i,
    input  wire logic        rst_n_i,

    // Asynchronous switch bank
    input  wire logic [15:0] switch_i,

    // Register port, read only
    input  wire logic        sel_i,
    input  wire logic [3:0]  reg_i,
    input  wire logic        read_enable_i,
    output word_t            read_data_o,

    output logic             change_o
);

    logic [15:0] sync1_r;
    logic [15:0] sync2_r;
    logic [15:0] state_r;

    // Two flops against metastability, then the held state
    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            sync1_r  <= '0;
            sync2_r  <= '0;
            state_r  <= '0;
            change_o <= 1'b0;
        end else begin
            sync1_r  <= switch_i;
            sync2_r  <= sync1_r;
            state_r  <= sync2_r;
            change_o <= (sync2_r != state_r);
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (sel_i && read_enable_i) begin
            if (reg_i == REG_SW_STATE) begin
                read_data_o <= word_t'(state_r);
            end else begin
                read_data_o <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/irq_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module irq_controller
    import io_pkg::*;
#(
    parameter int IRQ_COUNT = 2
) (
    input  wire logic                 cpu_clk_i,
    input  wire logic                 rst_n_i,

    // Register port
    input  wire logic                 sel_i,
    input  wire logic [3:0]           reg_i,
    input  wire logic                 read_enable_i,
    input  wire word_t                write_data_i,
    input  wire logic [3:0]           write_mask_i,
    output word_t                     read_data_o,

    // One-cycle source pulses
    input  wire logic [IRQ_COUNT-1:0] irq_i,
    output logic                      interrupt_o
);

    logic [IRQ_COUNT-1:0] pending_r;
    logic [IRQ_COUNT-1:0] enabled_r;
    logic [IRQ_COUNT-1:0] pending_kept;
    logic [IRQ_COUNT-1:0] enabled_next;
    logic [IRQ_COUNT-1:0] wr_bits;
    word_t                byte_bits;
    logic                 wr_en;

    assign byte_bits = {{8{write_mask_i[3]}}, {8{write_mask_i[2]}},
                        {8{write_mask_i[1]}}, {8{write_mask_i[0]}}};
    assign wr_bits   = write_data_i[IRQ_COUNT-1:0] & byte_bits[IRQ_COUNT-1:0];
    assign wr_en     = sel_i && (write_mask_i != 4'b0000);

    always_comb begin
        pending_kept = pending_r;
        enabled_next = enabled_r;
        // Write 1 to clear, so software can acknowledge
        if (wr_en && reg_i == REG_IRQ_PENDING) begin
            pending_kept = pending_r & ~wr_bits;
        end
        if (wr_en && reg_i == REG_IRQ_ENABLED) begin
            enabled_next = (enabled_r & ~byte_bits[IRQ_COUNT-1:0]) | wr_bits;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            pending_r   <= '0;
            enabled_r   <= '0;
            interrupt_o <= 1'b0;
        end else begin
            // A new pulse beats a clear on the same edge
            pending_r   <= pending_kept | irq_i;
            enabled_r   <= enabled_next;
            interrupt_o <= |(pending_kept & enabled_next);
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (sel_i && read_enable_i) begin
            case (reg_i)
                REG_IRQ_PENDING: read_data_o <= word_t'(pending_r);
                REG_IRQ_ENABLED: read_data_o <= word_t'(enabled_r);
                REG_IRQ_ACTIVE:  read_data_o <= word_t'(pending_r & enabled_r);
                default:         read_data_o <= '0;
            endcase
        end
    end

    // Masking everything must silence the CPU interrupt
    irq_needs_enable_a: assert property (
        @(posedge cpu_clk_i) disable iff (!rst_n_i)
        interrupt_o |-> (enabled_r != '0)
    );

endmodule

`default_nettype wire

// ==== rtl/io_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module io_decode
    import io_pkg::*;
(
    input  wire logic  cpu_clk_i,
    input  wire logic  rst_n_i,

    // CPU data bus address
    input  wire word_t addr_i,

    // Registered read words from the devices
    input  wire word_t irq_data_i,
    input  wire word_t dsp_data_i,
    input  wire word_t sw_data_i,

    // Device selects for the current address cycle
    output logic       irq_sel_o,
    output logic       dsp_sel_o,
    output logic       sw_sel_o,

    output word_t      read_data_o
);

    dev_sel_t dev_sel;
    dev_sel_t dev_sel_r;

    // Only the upper 24 bits pick the region
    assign irq_sel_o = (addr_i[31:8] == IRQ_BASE);
    assign dsp_sel_o = (addr_i[31:8] == DISPLAY_BASE);
    assign sw_sel_o  = (addr_i[31:8] == SWITCH_BASE);

    always_comb begin
        if (irq_sel_o) begin
            dev_sel = DEV_IRQ;
        end else if (dsp_sel_o) begin
            dev_sel = DEV_DISPLAY;
        end else if (sw_sel_o) begin
            dev_sel = DEV_SWITCHES;
        end else begin
            dev_sel = DEV_NONE;
        end
    end

    // Select lines up with the device's registered read word
    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            dev_sel_r <= DEV_NONE;
        end else begin
            dev_sel_r <= dev_sel;
        end
    end

    always_comb begin
        case (dev_sel_r)
            DEV_IRQ:      read_data_o = irq_data_i;
            DEV_DISPLAY:  read_data_o = dsp_data_i;
            DEV_SWITCHES: read_data_o = sw_data_i;
            default:      read_data_o = '0;
        endcase
    end

    // Overlapping regions would select two devices at once
    sel_onehot_a: assert property (
        @(posedge cpu_clk_i) disable iff (!rst_n_i)
        $onehot0({irq_sel_o, dsp_sel_o, sw_sel_o})
    );

endmodule

`default_nettype wire

// ==== rtl/io_pkg.sv ====
`default_nettype none

package io_pkg;

    // CPU data bus word
    typedef logic [31:0] word_t;

    // One select per mapped device
    typedef enum logic [1:0] {
        DEV_NONE,
        DEV_IRQ,
        DEV_DISPLAY,
        DEV_SWITCHES
    } dev_sel_t;

    // Address regions, compared against addr[31:8]
    localparam logic [23:0] IRQ_BASE     = 24'hFFFF00;
    localparam logic [23:0] DISPLAY_BASE = 24'hFFFF02;
    localparam logic [23:0] SWITCH_BASE  = 24'hFFFF03;

    // Register indices within a region, taken from addr[5:2]
    localparam logic [3:0] REG_IRQ_PENDING = 4'd0;
    localparam logic [3:0] REG_IRQ_ENABLED = 4'd1;
    localparam logic [3:0] REG_IRQ_ACTIVE  = 4'd2;
    localparam logic [3:0] REG_DSP_CONTROL = 4'd0;
    localparam logic [3:0] REG_DSP_VALUE   = 4'd1;
    localparam logic [3:0] REG_SW_STATE    = 4'd0;

    // Interrupt source bit positions
    localparam int IRQ_SW          = 0;
    localparam int IRQ_DSP_REFRESH = 1;

    // Active-low cathodes as {dp, g, f, e, d, c, b, a}, dp kept dark
    function automatic logic [7:0] hex_segments(input logic [3:0] nibble);
        case (nibble)
            4'h0: hex_segments = 8'hC0;
            4'h1: hex_segments = 8'hF9;
            4'h2: hex_segments = 8'hA4;
            4'h3: hex_segments = 8'hB0;
            4'h4: hex_segments = 8'h99;
            4'h5: hex_segments = 8'h92;
            4'h6: hex_segments = 8'h82;
            4'h7: hex_segments = 8'hF8;
            4'h8: hex_segments = 8'h80;
            4'h9: hex_segments = 8'h90;
            4'hA: hex_segments = 8'h88;
            4'hB: hex_segments = 8'h83;
            4'hC: hex_segments = 8'hC6;
            4'hD: hex_segments = 8'hA1;
            4'hE: hex_segments = 8'h86;
            default: hex_segments = 8'h8E;
        endcase
    endfunction

endpackage

`default_nettype wire
